// ==== Makefile ====
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -f filelist.f --top-module rammodel_tb -o Vrammodel_tb

run: compile
	./obj_dir/Vrammodel_tb | tee /dev/stderr | grep -q "Test completed successfully"

clean:
	rm -rf obj_dir

// ==== filelist.f ====
src/rammodel_pkg.sv
src/ready_valid_fork.sv
src/rammodel_tracker.sv
src/rammodel_tm_fixed.sv
src/rammodel_frontend.sv
src/rammodel_backend.sv
src/rammodel_top.sv
tests/clock_gen.sv
tests/rammodel_tb.sv

// ==== src/rammodel_backend.sv ====
`timescale 1ns/100ps

module rammodel_backend (
    input  logic                                target_clk,
    input  logic                                rst,
    input  logic                                a_valid,
    output logic                                a_ready,
    input  rammodel_pkg::a_op_e                 a_op,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   a_id,
    input  logic [rammodel_pkg::ADDR_WIDTH-1:0] a_addr,
    input  logic                                bw_valid,
    output logic                                bw_ready,
    input  logic [rammodel_pkg::DATA_WIDTH-1:0] bw_data,
    input  logic                                rreq_valid,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   rreq_id,
    input  logic                                breq_valid,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   breq_id,
    output logic                                be_bvalid,
    input  logic                                be_bready,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   be_bid,
    output logic                                be_rvalid,
    input  logic                                be_rready,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   be_rid,
    output logic [rammodel_pkg::DATA_WIDTH-1:0] be_rdata
);

    rammodel_pkg::backend_state_e               state;
    rammodel_pkg::a_op_e                        op_q;
    logic [rammodel_pkg::ID_WIDTH-1:0]          id_q;
    logic [$clog2(rammodel_pkg::MEM_WORDS)-1:0] idx_q;
    logic [rammodel_pkg::DATA_WIDTH-1:0]        mem [rammodel_pkg::MEM_WORDS];
    logic [2**rammodel_pkg::ID_WIDTH-1:0]       done_q;
    logic [2**rammodel_pkg::ID_WIDTH-1:0]       seen_q;
    logic [2**rammodel_pkg::ID_WIDTH-1:0]       is_rd_q;
    logic [rammodel_pkg::DATA_WIDTH-1:0]        slot_data [2**rammodel_pkg::ID_WIDTH];
    logic [2**rammodel_pkg::ID_WIDTH-1:0]       b_cand;
    logic [2**rammodel_pkg::ID_WIDTH-1:0]       r_cand;
    logic [rammodel_pkg::ID_WIDTH-1:0]          b_pick;
    logic [rammodel_pkg::ID_WIDTH-1:0]          r_pick;
    logic                                       b_load;
    logic                                       r_load;

    assign a_ready = state == rammodel_pkg::be_idle;
    assign bw_ready = state == rammodel_pkg::be_wait_data;

    // a slot may leave once the access is done and its strobe has come.
    assign b_cand = done_q & seen_q & ~is_rd_q;
    assign r_cand = done_q & seen_q & is_rd_q;
    assign b_load = !be_bvalid && (|b_cand);
    assign r_load = !be_rvalid && (|r_cand);

    // lowest ready id first.
    always_comb begin
        b_pick = '0;
        r_pick = '0;
        for (int i = 2**rammodel_pkg::ID_WIDTH - 1; i >= 0; i--) begin
            if (b_cand[i]) begin
                b_pick = i[rammodel_pkg::ID_WIDTH-1:0];
            end
            if (r_cand[i]) begin
                r_pick = i[rammodel_pkg::ID_WIDTH-1:0];
            end
        end
    end

    always_ff @(posedge target_clk) begin
        if (rst) begin
            state <= rammodel_pkg::be_idle;
            for (int i = 0; i < rammodel_pkg::MEM_WORDS; i++) begin
                mem[i] <= '0;
            end
        end else begin
            case (state)
                rammodel_pkg::be_idle: begin
                    if (a_valid && a_op == rammodel_pkg::op_write) begin
                        state <= rammodel_pkg::be_wait_data;
                    end else if (a_valid) begin
                        state <= rammodel_pkg::be_respond;
                    end
                end
                rammodel_pkg::be_wait_data: begin
                    if (bw_valid) begin
                        mem[idx_q] <= bw_data;
                        state <= rammodel_pkg::be_respond;
                    end
                end
                default: begin
                    state <= rammodel_pkg::be_idle;
                end
            endcase
        end
    end

    always_ff @(posedge target_clk) begin
        if (rst) begin
            done_q <= '0;
            seen_q <= '0;
            be_bvalid <= 1'b0;
            be_rvalid <= 1'b0;
        end else begin
            if (b_load) begin
                done_q[b_pick] <= 1'b0;
                seen_q[b_pick] <= 1'b0;
            end
            if (r_load) begin
                done_q[r_pick] <= 1'b0;
                seen_q[r_pick] <= 1'b0;
            end
            if (rreq_valid) begin
                seen_q[rreq_id] <= 1'b1;
            end
            if (breq_valid) begin
                seen_q[breq_id] <= 1'b1;
            end
            if (state == rammodel_pkg::be_respond) begin
                done_q[id_q] <= 1'b1;
            end
            if (b_load) begin
                be_bvalid <= 1'b1;
            end else if (be_bready) begin
                be_bvalid <= 1'b0;
            end
            if (r_load) begin
                be_rvalid <= 1'b1;
            end else if (be_rready) begin
                be_rvalid <= 1'b0;
            end
        end
    end

    always_ff @(posedge target_clk) begin
        if (a_valid && a_ready) begin
            op_q <= a_op;
            id_q <= a_id;
            idx_q <= a_addr[$clog2(rammodel_pkg::MEM_WORDS)+1:2];
        end
        if (state == rammodel_pkg::be_respond) begin
            is_rd_q[id_q] <= op_q == rammodel_pkg::op_read;
            slot_data[id_q] <= mem[idx_q];
        end
        if (b_load) begin
            be_bid <= b_pick;
        end
        if (r_load) begin
            be_rid <= r_pick;
            be_rdata <= slot_data[r_pick];
        end
    end

endmodule

// ==== src/rammodel_frontend.sv ====
`timescale 1ns/100ps

module rammodel_frontend (
    input  logic                                target_clk,
    input  logic                                rst,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   awid,
    input  logic [rammodel_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [rammodel_pkg::DATA_WIDTH-1:0] wdata,
    input  logic                                wlast,
    output logic                                bvalid,
    input  logic                                bready,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   bid,
    output logic [1:0]                          bresp,
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   arid,
    input  logic [rammodel_pkg::ADDR_WIDTH-1:0] araddr,
    output logic                                rvalid,
    input  logic                                rready,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   rid,
    output logic [rammodel_pkg::DATA_WIDTH-1:0] rdata,
    output logic [1:0]                          rresp,
    output logic                                rlast,
    output logic                                a_valid,
    input  logic                                a_ready,
    output rammodel_pkg::a_op_e                 a_op,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   a_id,
    output logic [rammodel_pkg::ADDR_WIDTH-1:0] a_addr,
    output logic                                bw_valid,
    input  logic                                bw_ready,
    output logic [rammodel_pkg::DATA_WIDTH-1:0] bw_data,
    input  logic                                be_bvalid,
    output logic                                be_bready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   be_bid,
    input  logic                                be_rvalid,
    output logic                                be_rready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   be_rid,
    input  logic [rammodel_pkg::DATA_WIDTH-1:0] be_rdata,
    output logic                                rreq_valid,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   rreq_id,
    output logic                                breq_valid,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   breq_id
);

    logic trk_awvalid, trk_awready;
    logic trk_wvalid, trk_wready;
    logic trk_arvalid, trk_arready;
    logic trk_bvalid, trk_bready;
    logic trk_rvalid, trk_rready;
    logic tm_awvalid, tm_awready;
    logic tm_wvalid, tm_wready;
    logic tm_arvalid, tm_arready;

    // request channels go to the timing model and the tracker.
    ready_valid_fork #(.BRANCHES(2)) fork_aw (
        .target_clk, .rst,
        .s_valid (awvalid),
        .s_ready (awready),
        .m_valid ({tm_awvalid, trk_awvalid}),
        .m_ready ({tm_awready, trk_awready})
    );

    ready_valid_fork #(.BRANCHES(2)) fork_w (
        .target_clk, .rst,
        .s_valid (wvalid),
        .s_ready (wready),
        .m_valid ({tm_wvalid, trk_wvalid}),
        .m_ready ({tm_wready, trk_wready})
    );

    ready_valid_fork #(.BRANCHES(2)) fork_ar (
        .target_clk, .rst,
        .s_valid (arvalid),
        .s_ready (arready),
        .m_valid ({tm_arvalid, trk_arvalid}),
        .m_ready ({tm_arready, trk_arready})
    );

    rammodel_tracker tracker_i (
        .target_clk, .rst,
        .awvalid (trk_awvalid), .awready (trk_awready), .awid, .awaddr,
        .wvalid  (trk_wvalid),  .wready  (trk_wready),  .wdata,
        .arvalid (trk_arvalid), .arready (trk_arready), .arid, .araddr,
        .bvalid  (trk_bvalid),  .bready  (trk_bready),
        .rvalid  (trk_rvalid),  .rready  (trk_rready),
        .a_valid, .a_ready, .a_op, .a_id, .a_addr,
        .bw_valid, .bw_ready, .bw_data
    );

    rammodel_tm_fixed timing_model_i (
        .target_clk, .rst,
        .arvalid (tm_arvalid), .arready (tm_arready), .arid,
        .awvalid (tm_awvalid), .awready (tm_awready), .awid,
        .wvalid  (tm_wvalid),  .wready  (tm_wready),  .wlast,
        .rreq_valid, .rreq_id, .breq_valid, .breq_id
    );

    // responses go back to the target and retire in the tracker.
    ready_valid_fork #(.BRANCHES(2)) fork_b (
        .target_clk, .rst,
        .s_valid (be_bvalid),
        .s_ready (be_bready),
        .m_valid ({bvalid, trk_bvalid}),
        .m_ready ({bready, trk_bready})
    );

    ready_valid_fork #(.BRANCHES(2)) fork_r (
        .target_clk, .rst,
        .s_valid (be_rvalid),
        .s_ready (be_rready),
        .m_valid ({rvalid, trk_rvalid}),
        .m_ready ({rready, trk_rready})
    );

    assign bid = be_bid;
    assign bresp = 2'b00;
    assign rid = be_rid;
    assign rdata = be_rdata;
    assign rresp = 2'b00;
    assign rlast = 1'b1;

endmodule

// ==== src/rammodel_pkg.sv ====
package rammodel_pkg;

    localparam int ADDR_WIDTH = 8;
    localparam int DATA_WIDTH = 32;
    localparam int ID_WIDTH = 4;

    // tracker limit on outstanding transactions.
    localparam int MAX_INFLIGHT = 4;

    // timing model delays in target clock cycles.
    localparam int R_DELAY = 25;
    localparam int W_DELAY = 3;

    // word index comes from address bits 5:2.
    localparam int MEM_WORDS = 16;

    typedef enum logic {
        op_read  = 1'b0,
        op_write = 1'b1
    } a_op_e;

    typedef enum logic [1:0] {
        be_idle,
        be_wait_data,
        be_respond
    } backend_state_e;

endpackage

// ==== src/rammodel_tm_fixed.sv ====
`timescale 1ns/100ps

module rammodel_tm_fixed (
    input  logic                              target_clk,
    input  logic                              rst,
    input  logic                              arvalid,
    output logic                              arready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0] arid,
    input  logic                              awvalid,
    output logic                              awready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0] awid,
    input  logic                              wvalid,
    output logic                              wready,
    input  logic                              wlast,
    output logic                              rreq_valid,
    output logic [rammodel_pkg::ID_WIDTH-1:0] rreq_id,
    output logic                              breq_valid,
    output logic [rammodel_pkg::ID_WIDTH-1:0] breq_id
);

    logic [rammodel_pkg::R_DELAY-1:0]  rd_v;
    logic [rammodel_pkg::ID_WIDTH-1:0] rd_id [rammodel_pkg::R_DELAY];
    logic [rammodel_pkg::W_DELAY-1:0]  wd_v;
    logic [rammodel_pkg::ID_WIDTH-1:0] wd_id [rammodel_pkg::W_DELAY];
    logic                              aw_held;
    logic                              w_held;
    logic [rammodel_pkg::ID_WIDTH-1:0] aw_id_q;
    logic                              ar_hs;
    logic                              aw_hs;
    logic                              w_hs;
    logic                              pair;
    logic [rammodel_pkg::ID_WIDTH-1:0] pair_id;

    // one read enters the line per cycle, so it never fills.
    assign arready = 1'b1;

    // hold off the side that is already waiting for its partner.
    assign awready = !aw_held;
    assign wready = !w_held;

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs = wvalid && wready && wlast;
    assign pair = (aw_held || aw_hs) && (w_held || w_hs);
    assign pair_id = aw_held ? aw_id_q : awid;

    always_ff @(posedge target_clk) begin
        if (rst) begin
            rd_v <= '0;
            wd_v <= '0;
            aw_held <= 1'b0;
            w_held <= 1'b0;
            rreq_valid <= 1'b0;
            breq_valid <= 1'b0;
        end else begin
            rd_v <= {rd_v[rammodel_pkg::R_DELAY-2:0], ar_hs};
            wd_v <= {wd_v[rammodel_pkg::W_DELAY-2:0], pair};
            // output register makes the pulse land exactly on the delay.
            rreq_valid <= rd_v[rammodel_pkg::R_DELAY-1];
            breq_valid <= wd_v[rammodel_pkg::W_DELAY-1];
            if (pair) begin
                aw_held <= 1'b0;
                w_held <= 1'b0;
            end else begin
                if (aw_hs) begin
                    aw_held <= 1'b1;
                end
                if (w_hs) begin
                    w_held <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge target_clk) begin
        rd_id[0] <= arid;
        for (int i = 1; i < rammodel_pkg::R_DELAY; i++) begin
            rd_id[i] <= rd_id[i-1];
        end
        wd_id[0] <= pair_id;
        for (int i = 1; i < rammodel_pkg::W_DELAY; i++) begin
            wd_id[i] <= wd_id[i-1];
        end
        rreq_id <= rd_id[rammodel_pkg::R_DELAY-1];
        breq_id <= wd_id[rammodel_pkg::W_DELAY-1];
        if (aw_hs) begin
            aw_id_q <= awid;
        end
    end

endmodule

// ==== src/rammodel_top.sv ====
`timescale 1ns/100ps

module rammodel_top (
    input  logic                                target_clk,
    input  logic                                rst,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   awid,
    input  logic [rammodel_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [rammodel_pkg::DATA_WIDTH-1:0] wdata,
    input  logic                                wlast,
    output logic                                bvalid,
    input  logic                                bready,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   bid,
    output logic [1:0]                          bresp,
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   arid,
    input  logic [rammodel_pkg::ADDR_WIDTH-1:0] araddr,
    output logic                                rvalid,
    input  logic                                rready,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   rid,
    output logic [rammodel_pkg::DATA_WIDTH-1:0] rdata,
    output logic [1:0]                          rresp,
    output logic                                rlast
);

    // back-end request and write data.
    logic                                a_valid;
    logic                                a_ready;
    rammodel_pkg::a_op_e                 a_op;
    logic [rammodel_pkg::ID_WIDTH-1:0]   a_id;
    logic [rammodel_pkg::ADDR_WIDTH-1:0] a_addr;
    logic                                bw_valid;
    logic                                bw_ready;
    logic [rammodel_pkg::DATA_WIDTH-1:0] bw_data;

    // back-end responses.
    logic                                be_bvalid;
    logic                                be_bready;
    logic [rammodel_pkg::ID_WIDTH-1:0]   be_bid;
    logic                                be_rvalid;
    logic                                be_rready;
    logic [rammodel_pkg::ID_WIDTH-1:0]   be_rid;
    logic [rammodel_pkg::DATA_WIDTH-1:0] be_rdata;

    // release strobes from the timing model.
    logic                                rreq_valid;
    logic [rammodel_pkg::ID_WIDTH-1:0]   rreq_id;
    logic                                breq_valid;
    logic [rammodel_pkg::ID_WIDTH-1:0]   breq_id;

    rammodel_frontend frontend_i (.*);

    rammodel_backend backend_i (.*);

endmodule

// ==== src/rammodel_tracker.sv ====
`timescale 1ns/100ps

module rammodel_tracker (
    input  logic                                target_clk,
    input  logic                                rst,
    input  logic                                awvalid,
    output logic                                awready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   awid,
    input  logic [rammodel_pkg::ADDR_WIDTH-1:0] awaddr,
    input  logic                                wvalid,
    output logic                                wready,
    input  logic [rammodel_pkg::DATA_WIDTH-1:0] wdata,
    input  logic                                arvalid,
    output logic                                arready,
    input  logic [rammodel_pkg::ID_WIDTH-1:0]   arid,
    input  logic [rammodel_pkg::ADDR_WIDTH-1:0] araddr,
    input  logic                                bvalid,
    output logic                                bready,
    input  logic                                rvalid,
    output logic                                rready,
    output logic                                a_valid,
    input  logic                                a_ready,
    output rammodel_pkg::a_op_e                 a_op,
    output logic [rammodel_pkg::ID_WIDTH-1:0]   a_id,
    output logic [rammodel_pkg::ADDR_WIDTH-1:0] a_addr,
    output logic                                bw_valid,
    input  logic                                bw_ready,
    output logic [rammodel_pkg::DATA_WIDTH-1:0] bw_data
);

    typedef logic [$clog2(rammodel_pkg::MAX_INFLIGHT+1)-1:0] count_t;

    count_t count;
    logic   full;
    logic   slot_free;
    logic   aw_hs;
    logic   ar_hs;
    logic   b_hs;
    logic   r_hs;

    assign full = int'(count) >= rammodel_pkg::MAX_INFLIGHT;
    assign slot_free = !a_valid || a_ready;

    // writes win when both address channels are pending.
    assign awready = !full && slot_free;
    assign arready = !full && slot_free && !awvalid;

    assign aw_hs = awvalid && awready;
    assign ar_hs = arvalid && arready;
    assign b_hs = bvalid && bready;
    assign r_hs = rvalid && rready;

    // responses are never stalled on this side.
    assign bready = 1'b1;
    assign rready = 1'b1;

    // single beat writes, so data goes straight to the back end.
    assign bw_valid = wvalid;
    assign wready = bw_ready;
    assign bw_data = wdata;

    always_ff @(posedge target_clk) begin
        if (rst) begin
            a_valid <= 1'b0;
            count <= '0;
        end else begin
            if (aw_hs || ar_hs) begin
                a_valid <= 1'b1;
            end else if (a_ready) begin
                a_valid <= 1'b0;
            end
            count <= count + count_t'(aw_hs || ar_hs) - count_t'(b_hs) - count_t'(r_hs);
        end
    end

    always_ff @(posedge target_clk) begin
        if (aw_hs) begin
            a_op <= rammodel_pkg::op_write;
            a_id <= awid;
            a_addr <= awaddr;
        end else if (ar_hs) begin
            a_op <= rammodel_pkg::op_read;
            a_id <= arid;
            a_addr <= araddr;
        end
    end

endmodule

// ==== src/ready_valid_fork.sv ====
`timescale 1ns/100ps

module ready_valid_fork #(
    parameter int BRANCHES = 2
) (
    input  logic                target_clk,
    input  logic                rst,
    input  logic                s_valid,
    output logic                s_ready,
    output logic [BRANCHES-1:0] m_valid,
    input  logic [BRANCHES-1:0] m_ready
);

    logic [BRANCHES-1:0] done;
    logic [BRANCHES-1:0] taken;

    // a branch has the item if it took it earlier or takes it now.
    assign taken = done | (m_valid & m_ready);
    assign s_ready = &taken;
    assign m_valid = {BRANCHES{s_valid}} & ~done;

    always_ff @(posedge target_clk) begin
        if (rst) begin
            done <= '0;
        end else if (s_valid && s_ready) begin
            done <= '0;
        end else if (s_valid) begin
            done <= taken;
        end
    end

endmodule

// ==== tests/clock_gen.sv ====
`timescale 1ns/100ps

module clock_gen (
    output logic target_clk,
    output logic rst
);

    initial begin
        target_clk = 1'b0;
        forever #4 target_clk = ~target_clk;
    end

    // reset held for the first ten rising edges.
    initial begin
        rst = 1'b1;
        repeat (10) @(posedge target_clk);
        #1 rst = 1'b0;
    end

endmodule

// ==== tests/rammodel_cases.txt ====
# op(0 read, 1 write) id addr wdata expected_rdata stall, all hex
# word index is addr[5:2]; expected_rdata is the last data written to that word
0 1 00 00000000 00000000 0
0 2 3c 00000000 00000000 0
1 3 04 a5a5a5a5 00000000 0
1 4 08 12345678 00000000 0
1 5 3c deadbeef 00000000 0
0 6 04 00000000 a5a5a5a5 0
0 7 08 00000000 12345678 0
0 8 04 00000000 a5a5a5a5 0
0 9 08 00000000 12345678 0
0 a 3c 00000000 deadbeef 0
0 b 0c 00000000 00000000 0
0 c 44 00000000 a5a5a5a5 0
0 d 48 00000000 12345678 0
1 1 10 cafef00d 00000000 1
1 2 14 0badc0de 00000000 1
0 3 10 00000000 cafef00d 1
0 4 14 00000000 0badc0de 1
1 5 04 11112222 00000000 1
0 6 04 00000000 11112222 1
0 7 44 00000000 11112222 1
1 8 3c 55aa55aa 00000000 1
0 9 3c 00000000 55aa55aa 1
0 a 7c 00000000 55aa55aa 1
0 b 20 00000000 00000000 0

// ==== tests/rammodel_tb.sv ====
`timescale 1ns/100ps

module rammodel_tb;

    localparam int IDS = 2**rammodel_pkg::ID_WIDTH;

    logic                                target_clk, rst;
    logic                                awvalid, awready, wvalid, wready, wlast;
    logic [rammodel_pkg::ID_WIDTH-1:0]   awid, arid, bid, rid;
    logic [rammodel_pkg::ADDR_WIDTH-1:0] awaddr, araddr;
    logic [rammodel_pkg::DATA_WIDTH-1:0] wdata, rdata;
    logic                                bvalid, bready, arvalid, arready;
    logic                                rvalid, rready, rlast;
    logic [1:0]                          bresp, rresp;

    // case table loaded from the cases file.
    logic                                case_op [64];
    logic [rammodel_pkg::ID_WIDTH-1:0]   case_id [64];
    logic [rammodel_pkg::ADDR_WIDTH-1:0] case_addr [64];
    logic [rammodel_pkg::DATA_WIDTH-1:0] case_wdata [64];
    logic [rammodel_pkg::DATA_WIDTH-1:0] case_rdata [64];
    logic                                case_stall [64];
    int                                  n_cases;

    // scoreboard per ID.
    logic                                pend_w [IDS];
    logic                                pend_r [IDS];
    logic [rammodel_pkg::DATA_WIDTH-1:0] exp_rdata [IDS];
    int                                  wr_edge [IDS];
    int                                  ar_edge [IDS];
    logic [rammodel_pkg::ID_WIDTH-1:0]   rd_order [$];
    logic [rammodel_pkg::ID_WIDTH-1:0]   b_hold_id, r_hold_id;
    logic [rammodel_pkg::DATA_WIDTH-1:0] r_hold_data;
    logic                                b_wait, r_wait, stall_mode;
    int                                  num_pending, inflight, errors, cycle, limit;
    integer                              seed;

    clock_gen clock_gen_i (.target_clk, .rst);

    rammodel_top dut_i (.*);

    always @(posedge target_clk) begin
        cycle = cycle + 1;
        if (limit > 0 && cycle >= limit) begin
            $display("timeout after %0d cycles, responses still missing: %0d", cycle, num_pending);
            $display("Test failed");
            $finish;
        end
    end

    // response ready, random while a stalling case runs.
    always @(posedge target_clk) begin
        #1;
        if (stall_mode) begin
            bready = 1'($random(seed));
            rready = 1'($random(seed));
        end else begin
            bready = 1'b1;
            rready = 1'b1;
        end
    end

    task automatic check_write_response();
        if (b_wait && !bvalid) begin
            $display("bvalid dropped at %0t before its handshake", $time);
            errors++;
            b_wait = 1'b0;
        end
        if (bvalid) begin
            if (b_wait && bid !== b_hold_id) begin
                $display("FAIL %0t bid expected %h actual %h", $time, b_hold_id, bid);
                errors++;
            end
            if (!b_wait) begin
                inflight--;
                if (!pend_w[bid]) begin
                    $display("write response at %0t for ID %h that has no write open", $time, bid);
                    errors++;
                end
                if (cycle - wr_edge[bid] < rammodel_pkg::W_DELAY + 1) begin
                    $display("FAIL %0t bvalid latency expected >= %0d actual %0d", $time,
                             rammodel_pkg::W_DELAY + 1, cycle - wr_edge[bid]);
                    errors++;
                end
                if (bresp !== 2'b00) begin
                    $display("FAIL %0t bresp expected %h actual %h", $time, 2'b00, bresp);
                    errors++;
                end
            end
            if (bready) begin
                pend_w[bid] = 1'b0;
                num_pending--;
                b_wait = 1'b0;
            end else begin
                b_wait = 1'b1;
                b_hold_id = bid;
            end
        end
    endtask

    task automatic check_read_response();
        if (r_wait && !rvalid) begin
            $display("rvalid dropped at %0t before its handshake", $time);
            errors++;
            r_wait = 1'b0;
        end
        if (rvalid) begin
            if (r_wait && (rid !== r_hold_id || rdata !== r_hold_data)) begin
                $display("FAIL %0t rid/rdata expected %h/%h actual %h/%h", $time,
                         r_hold_id, r_hold_data, rid, rdata);
                errors++;
            end
            if (!r_wait) begin
                inflight--;
                if (!pend_r[rid] || rd_order.size() == 0) begin
                    $display("read response at %0t for ID %h that has no read open", $time, rid);
                    errors++;
                end else if (rid !== rd_order[0]) begin
                    $display("FAIL %0t rid expected %h actual %h", $time, rd_order[0], rid);
                    errors++;
                end
                if (cycle - ar_edge[rid] < rammodel_pkg::R_DELAY + 1) begin
                    $display("FAIL %0t rvalid latency expected >= %0d actual %0d", $time,
                             rammodel_pkg::R_DELAY + 1, cycle - ar_edge[rid]);
                    errors++;
                end
                if (rdata !== exp_rdata[rid]) begin
                    $display("FAIL %0t rdata expected %h actual %h", $time, exp_rdata[rid], rdata);
                    errors++;
                end
                if (rresp !== 2'b00 || rlast !== 1'b1) begin
                    $display("FAIL %0t rresp/rlast expected 0/1 actual %h/%b", $time, rresp, rlast);
                    errors++;
                end
            end
            if (rready) begin
                pend_r[rid] = 1'b0;
                num_pending--;
                r_wait = 1'b0;
                if (rd_order.size() > 0) begin
                    void'(rd_order.pop_front());
                end
            end else begin
                r_wait = 1'b1;
                r_hold_id = rid;
                r_hold_data = rdata;
            end
        end
    endtask

    // sampled mid-cycle; a handshake seen here completes on the next rising edge.
    always @(negedge target_clk) begin
        if (!rst) begin
            if (arvalid && arready) begin
                rd_order.push_back(arid);
                inflight++;
            end
            if (awvalid && awready) begin
                inflight++;
            end
            check_write_response();
            check_read_response();
            if (inflight > rammodel_pkg::MAX_INFLIGHT) begin
                $display("more than %0d transactions accepted at %0t",
                         rammodel_pkg::MAX_INFLIGHT, $time);
                errors++;
            end
        end
    end

    task automatic issue_write(input int k);
        logic aw_done, w_done, aw_hs, w_hs;
        pend_w[case_id[k]] = 1'b1;
        num_pending++;
        awid = case_id[k];
        awaddr = case_addr[k];
        wdata = case_wdata[k];
        awvalid = 1'b1;
        wvalid = 1'b1;
        // the timing model pairs AW and W on the first edge they are offered.
        wr_edge[case_id[k]] = cycle + 1;
        aw_done = 1'b0;
        w_done = 1'b0;
        while (!(aw_done && w_done)) begin
            @(negedge target_clk);
            aw_hs = awvalid && awready;
            w_hs = wvalid && wready;
            @(posedge target_clk);
            #1;
            if (aw_hs) begin
                awvalid = 1'b0;
                aw_done = 1'b1;
            end
            if (w_hs) begin
                wvalid = 1'b0;
                w_done = 1'b1;
            end
        end
    endtask

    task automatic issue_read(input int k);
        logic ar_done;
        pend_r[case_id[k]] = 1'b1;
        exp_rdata[case_id[k]] = case_rdata[k];
        num_pending++;
        arid = case_id[k];
        araddr = case_addr[k];
        arvalid = 1'b1;
        // the timing model takes AR on the first edge it is offered.
        ar_edge[case_id[k]] = cycle + 1;
        ar_done = 1'b0;
        while (!ar_done) begin
            @(negedge target_clk);
            ar_done = arready;
            @(posedge target_clk);
            #1;
        end
        arvalid = 1'b0;
    endtask

    task automatic drain_responses();
        while (num_pending != 0) begin
            @(posedge target_clk);
            #1;
        end
    endtask

    initial begin
        int    fd;
        string header;
        {awvalid, wvalid, arvalid, bready, rready} = '0;
        {awid, arid, awaddr, araddr, wdata} = '0;
        wlast = 1'b1;
        {b_wait, r_wait, stall_mode} = '0;
        {num_pending, inflight, errors, cycle, limit, n_cases} = '0;
        seed = 32'h1fd7;
        for (int i = 0; i < IDS; i++) begin
            pend_w[i] = 1'b0;
            pend_r[i] = 1'b0;
        end
        fd = $fopen("tests/rammodel_cases.txt", "r");
        if (fd == 0) begin
            $display("cannot open tests/rammodel_cases.txt");
            $display("Test failed");
            $finish;
        end else begin
            void'($fgets(header, fd));
            void'($fgets(header, fd));
            while (n_cases < 64 && $fscanf(fd, "%h %h %h %h %h %h\n", case_op[n_cases],
                   case_id[n_cases], case_addr[n_cases], case_wdata[n_cases],
                   case_rdata[n_cases], case_stall[n_cases]) == 6) begin
                n_cases++;
            end
            $fclose(fd);
            limit = (n_cases + 8) * (rammodel_pkg::R_DELAY + 20);
            @(negedge rst);
            @(negedge target_clk);
            if (bvalid !== 1'b0 || rvalid !== 1'b0) begin
                $display("FAIL %0t bvalid/rvalid expected 0/0 actual %b/%b", $time, bvalid, rvalid);
                errors++;
            end
            @(posedge target_clk);
            #1;
            for (int k = 0; k < n_cases; k++) begin
                // an ID is reused only once everything open has returned.
                if (pend_w[case_id[k]] || pend_r[case_id[k]]) begin
                    drain_responses();
                end
                stall_mode = case_stall[k];
                if (case_op[k]) begin
                    issue_write(k);
                end else begin
                    issue_read(k);
                end
            end
            drain_responses();
            repeat (5) @(posedge target_clk);
            $display("cases run: %0d, errors: %0d", n_cases, errors);
            if (errors == 0) begin
                $display("Test completed successfully");
            end else begin
                $display("Test failed");
            end
            $finish;
        end
    end

endmodule
